// File: list.f
+incdir+rtl
rtl/psram_pkg.sv
rtl/apb_bank_decoder.sv
rtl/psram_bank_ctrl.sv
rtl/bank_response_mux.sv
rtl/psram_subsystem_top.sv
test/psram_model.sv
test/tb_psram_subsystem.sv

// File: Bender.yml
package:
  name: psram_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/psram_pkg.sv
      - rtl/apb_bank_decoder.sv
      - rtl/psram_bank_ctrl.sv
      - rtl/bank_response_mux.sv
      - rtl/psram_subsystem_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - test/psram_model.sv
      - test/tb_psram_subsystem.sv

// File: test/tb_psram_subsystem.sv
`include "psram_cfg.svh"

module tb_psram_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB         = `PSRAM_NUM_BANKS;
    localparam int DW         = `PSRAM_DATA_W;
    localparam int SW         = DW / 8;
    localparam int DEPTH      = 1 << `PSRAM_ADDR_W;
    localparam int BANK_LAT   = `PSRAM_LATENCY + 5;
    localparam int N_XFERS    = 72;
    // Each transfer costs setup, access and the wait states, plus reset
    localparam int MAX_CYCLES = 5 + N_XFERS * (`PSRAM_LATENCY + 8) + 100;

    logic                               clk50MHz;
    logic                               rst_n;
    logic [`PSRAM_PADDR_W-1:0]          paddr;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [DW-1:0]                      pwdata;
    logic [SW-1:0]                      pstrb;
    logic [DW-1:0]                      prdata;
    logic                               pready;
    logic                               pslverr;
    psram_pkg::psram_ctl_t [NB-1:0]     mem_ctl;
    wire  [NB-1:0][DW-1:0]              mem_data;

    logic [DW-1:0]  shadow [NB][DEPTH];
    int             data_errs = 0;
    int             resp_errs = 0;
    int             lat_errs = 0;
    int             ctl_errs = 0;
    int             cycle_cnt = 0;

    psram_subsystem_top dut0 (
        .clk50MHz (clk50MHz),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .mem_ctl  (mem_ctl),
        .mem_data (mem_data)
    );

    for (genvar g = 0; g < NB; g++) begin : g_mem
        psram_model #(.BANK_ID(g)) u_mem (
            .ctl  (mem_ctl[g]),
            .data (mem_data[g])
        );
    end

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    always @(posedge clk50MHz) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // Output and write enable low together would short the chip bus
    always @(negedge clk50MHz) begin
        if (rst_n === 1'b1) begin
            for (int b = 0; b < NB; b++) begin
                if (mem_ctl[b].oe_n === 1'b0 && mem_ctl[b].we_n === 1'b0) begin
                    ctl_errs++;
                    $display("Bank %0d has oe_n and we_n low together at %0t", b, $time);
                end
            end
        end
    end

    function automatic logic [DW-1:0] fill_word(input int bank, input int word);
        return DW'(bank * 32'h1000 + word) ^ DW'('h5a5a);
    endfunction

    // Byte address with the bank number above the word address
    function automatic logic [`PSRAM_PADDR_W-1:0] bank_addr(input int bank, input int word);
        return (`PSRAM_PADDR_W'(bank) << (`PSRAM_ADDR_W + 1)) | (`PSRAM_PADDR_W'(word) << 1);
    endfunction

    task automatic check_data(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            resp_errs++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            lat_errs++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Control pins only, the address is free while the chip is deselected
    task automatic check_ctl(input string name, input psram_pkg::psram_ctl_t got,
                             input psram_pkg::psram_ctl_t exp);
        logic [6:0] g;
        logic [6:0] e;
        g = {got.ce_n, got.adv_n, got.oe_n, got.we_n, got.ub_n, got.lb_n, got.cre};
        e = {exp.ce_n, exp.adv_n, exp.oe_n, exp.we_n, exp.ub_n, exp.lb_n, exp.cre};
        if (g !== e) begin
            ctl_errs++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, g, e);
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic run_transfer(
        input  logic                        wr,
        input  logic [`PSRAM_PADDR_W-1:0]   addr,
        input  logic [DW-1:0]               wdata,
        input  logic [SW-1:0]               strb,
        output logic [DW-1:0]               rdata,
        output logic                        err,
        output int                          lat
    );
        int n;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        pstrb   = strb;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk50MHz);
        penable = 1'b1;
        n = 0;
        do begin
            @(negedge clk50MHz);
            n++;
        end while (pready !== 1'b1);
        rdata = prdata;
        err   = pslverr;
        // Edge where pready rose, counted from the first access edge
        lat   = n - 1;
        @(negedge clk50MHz);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`PSRAM_PADDR_W-1:0] addr, input logic [DW-1:0] data,
                             input logic [SW-1:0] strb, output logic err, output int lat);
        logic [DW-1:0] unused;
        run_transfer(1'b1, addr, data, strb, unused, err, lat);
    endtask

    task automatic apb_read(input logic [`PSRAM_PADDR_W-1:0] addr, output logic [DW-1:0] data,
                            output logic err, output int lat);
        run_transfer(1'b0, addr, '0, '0, data, err, lat);
    endtask

    task automatic write_word(input int bank, input int word, input logic [DW-1:0] data,
                              input logic [SW-1:0] strb);
        logic err;
        int   lat;
        apb_write(bank_addr(bank, word), data, strb, err, lat);
        check_resp($sformatf("pslverr write bank %0d word %0h", bank, word), err, 1'b0);
        for (int i = 0; i < SW; i++) begin
            if (strb[i]) begin
                shadow[bank][word][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic read_check(input int bank, input int word);
        logic [DW-1:0] data;
        logic          err;
        int            lat;
        apb_read(bank_addr(bank, word), data, err, lat);
        check_resp($sformatf("pslverr read bank %0d word %0h", bank, word), err, 1'b0);
        check_data($sformatf("prdata bank %0d word %0h", bank, word), data, shadow[bank][word]);
    endtask

    task automatic check_reset_state;
        psram_pkg::psram_ctl_t idle;
        idle = '{ce_n: 1'b1, adv_n: 1'b1, oe_n: 1'b1, we_n: 1'b1, ub_n: 1'b1, lb_n: 1'b1,
                 cre: 1'b0, addr: '0};
        for (int b = 0; b < NB; b++) begin
            check_ctl($sformatf("mem_ctl[%0d] in reset", b), mem_ctl[b], idle);
        end
        check_resp("pready in reset", pready, 1'b0);
        check_resp("pslverr in reset", pslverr, 1'b0);
    endtask

    task automatic test_full_word;
        write_word(0, 'h010, 16'hbeef, 2'b11);
        read_check(0, 'h010);
    endtask

    // Same word address, different value in every chip
    task automatic test_bank_isolation;
        for (int b = 0; b < NB; b++) begin
            write_word(b, 'h020, 16'hc0de ^ DW'(b * 16'h0f0f), 2'b11);
        end
        for (int b = 0; b < NB; b++) begin
            read_check(b, 'h020);
        end
    endtask

    task automatic test_byte_strobes;
        write_word(1, 'h030, 16'ha5c3, 2'b11);
        write_word(1, 'h030, 16'h5a7e, 2'b01);
        read_check(1, 'h030);
    endtask

    task automatic test_out_of_range;
        logic [DW-1:0] data;
        logic          err;
        int            lat;
        apb_write(bank_addr(NB, 'h040), 16'hdead, 2'b11, err, lat);
        check_resp("pslverr write out of range", err, 1'b1);
        apb_read(bank_addr(NB, 'h040), data, err, lat);
        check_resp("pslverr read out of range", err, 1'b1);
        for (int b = 0; b < NB; b++) begin
            read_check(b, 'h040);
        end
    endtask

    task automatic test_latency;
        logic [DW-1:0] data;
        logic          err;
        int            lat;
        apb_read(bank_addr(2, 'h050), data, err, lat);
        check_cycles("pready delay bank read", lat, BANK_LAT);
        check_data("prdata bank 2 word 50", data, shadow[2]['h050]);
        apb_write(bank_addr(3, 'h050), 16'h0f1e, 2'b11, err, lat);
        check_cycles("pready delay bank write", lat, BANK_LAT);
        shadow[3]['h050] = 16'h0f1e;
        apb_write(bank_addr(NB + 1, 0), 16'h1111, 2'b11, err, lat);
        check_cycles("pready delay error", lat, 2);
    endtask

    task automatic test_random;
        int bank;
        int word;
        for (int i = 0; i < 50; i++) begin
            bank = $urandom_range(NB - 1, 0);
            word = $urandom_range(31, 0);
            if ($urandom_range(1, 0) == 1) begin
                write_word(bank, word, DW'($urandom), SW'($urandom));
            end else begin
                read_check(bank, word);
            end
        end
    endtask

    initial begin
        void'($urandom(32'he350_0b20));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        for (int b = 0; b < NB; b++) begin
            for (int w = 0; w < DEPTH; w++) begin
                shadow[b][w] = fill_word(b, w);
            end
        end
        repeat (5) @(negedge clk50MHz);
        check_reset_state();
        rst_n = 1'b1;
        test_full_word();
        test_bank_isolation();
        test_byte_strobes();
        test_out_of_range();
        test_latency();
        test_random();
        $display("Errors: data %0d, response %0d, latency %0d, control %0d",
                 data_errs, resp_errs, lat_errs, ctl_errs);
        if (data_errs + resp_errs + lat_errs + ctl_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: test/psram_model.sv
`include "psram_cfg.svh"

module psram_model #(
    parameter int BANK_ID = 0
) (
    input  psram_pkg::psram_ctl_t           ctl,
    inout  wire [`PSRAM_DATA_W-1:0]         data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << `PSRAM_ADDR_W;

    logic [`PSRAM_DATA_W-1:0]   mem [DEPTH];
    logic [`PSRAM_DATA_W-1:0]   rd_word;
    logic                       rd_en;

    // Fill pattern from bank number and the whole word address
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = `PSRAM_DATA_W'(BANK_ID * 32'h1000 + a) ^ `PSRAM_DATA_W'('h5a5a);
        end
    end

    // Chip takes the data on the rising edge of we_n
    always @(posedge ctl.we_n) begin
        if (ctl.ce_n === 1'b0) begin
            if (ctl.lb_n === 1'b0) begin
                mem[ctl.addr][7:0] = data[7:0];
            end
            if (ctl.ub_n === 1'b0) begin
                mem[ctl.addr][15:8] = data[15:8];
            end
        end
    end

    assign rd_en   = (ctl.ce_n === 1'b0) && (ctl.oe_n === 1'b0);
    assign rd_word = mem[ctl.addr];

    // Each byte lane driven only when its enable is low
    assign data[15:8] = (rd_en && ctl.ub_n === 1'b0) ? rd_word[15:8] : 8'bz;
    assign data[7:0]  = (rd_en && ctl.lb_n === 1'b0) ? rd_word[7:0] : 8'bz;

endmodule

// File: rtl/psram_subsystem_top.sv
`include "psram_cfg.svh"

module psram_subsystem_top (
    input  logic                                          clk50MHz,
    input  logic                                          rst_n,
    input  logic [`PSRAM_PADDR_W-1:0]                     paddr,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [`PSRAM_DATA_W-1:0]                      pwdata,
    input  logic [`PSRAM_DATA_W/8-1:0]                    pstrb,
    output logic [`PSRAM_DATA_W-1:0]                      prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output psram_pkg::psram_ctl_t [`PSRAM_NUM_BANKS-1:0]  mem_ctl,
    inout  wire [`PSRAM_NUM_BANKS-1:0][`PSRAM_DATA_W-1:0] mem_data
);
    psram_pkg::bank_req_t [`PSRAM_NUM_BANKS-1:0]  bank_req;
    psram_pkg::bank_rsp_t [`PSRAM_NUM_BANKS-1:0]  bank_rsp;
    logic                                         dec_err;
    logic                                         rsp_busy;

    apb_bank_decoder u_decoder (
        .clk50MHz (clk50MHz),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .busy     (rsp_busy),
        .req      (bank_req),
        .err      (dec_err)
    );

    // One controller per chip
    for (genvar g = 0; g < `PSRAM_NUM_BANKS; g++) begin : g_bank
        psram_bank_ctrl u_ctrl (
            .clk50MHz (clk50MHz),
            .rst_n    (rst_n),
            .req      (bank_req[g]),
            .ctl      (mem_ctl[g]),
            .mdata    (mem_data[g]),
            .rsp      (bank_rsp[g])
        );
    end

    bank_response_mux u_rsp_mux (
        .clk50MHz (clk50MHz),
        .rst_n    (rst_n),
        .rsp      (bank_rsp),
        .err      (dec_err),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (rsp_busy)
    );

endmodule

// File: rtl/bank_response_mux.sv
`include "psram_cfg.svh"

module bank_response_mux (
    input  logic                                         clk50MHz,
    input  logic                                         rst_n,
    input  psram_pkg::bank_rsp_t [`PSRAM_NUM_BANKS-1:0]  rsp,
    input  logic                                         err,
    output logic [`PSRAM_DATA_W-1:0]                     prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    output logic                                         busy
);
    logic [`PSRAM_NUM_BANKS-1:0]    done_vec;
    logic                           any_done;
    logic [`PSRAM_DATA_W-1:0]       sel_data;

    // Only the completing bank contributes its read data
    always_comb begin
        sel_data = '0;
        for (int b = 0; b < `PSRAM_NUM_BANKS; b++) begin
            done_vec[b] = rsp[b].done;
            if (rsp[b].done) begin
                sel_data = sel_data | rsp[b].rdata;
            end
        end
    end

    assign any_done = |done_vec;

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= any_done || err;
            pslverr <= err;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (any_done) begin
            prdata <= sel_data;
        end else if (err) begin
            prdata <= '0;
        end
    end

    // Held through the completing APB edge so the decoder does not restart
    assign busy = pready;

    // Only one transfer is ever in flight across all banks and the error path
    assert property (@(posedge clk50MHz) disable iff (!rst_n) $onehot0({done_vec, err}))
        else $error("more than one completion in a cycle");

endmodule

// File: rtl/psram_bank_ctrl.sv
`include "psram_cfg.svh"

module psram_bank_ctrl (
    input  logic                        clk50MHz,
    input  logic                        rst_n,
    input  psram_pkg::bank_req_t        req,
    output psram_pkg::psram_ctl_t       ctl,
    inout  wire [`PSRAM_DATA_W-1:0]     mdata,
    output psram_pkg::bank_rsp_t        rsp
);
    localparam int CNT_W = $clog2(`PSRAM_LATENCY + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_WAIT,
        S_RDATA,
        S_WDATA
    } state_t;

    state_t                     state;
    logic [CNT_W-1:0]           lat_cnt;
    logic                       write_q;
    logic                       drv_q;
    logic                       done_q;
    logic [`PSRAM_DATA_W-1:0]   wdata_q;
    logic [`PSRAM_DATA_W-1:0]   rdata_q;

    // Data bus is ours only during a write
    assign mdata = drv_q ? wdata_q : 'z;

    assign rsp.done  = done_q;
    assign rsp.rdata = rdata_q;

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            lat_cnt   <= '0;
            write_q   <= 1'b0;
            drv_q     <= 1'b0;
            done_q    <= 1'b0;
            ctl.ce_n  <= 1'b1;
            ctl.adv_n <= 1'b1;
            ctl.oe_n  <= 1'b1;
            ctl.we_n  <= 1'b1;
            ctl.ub_n  <= 1'b1;
            ctl.lb_n  <= 1'b1;
            // Configuration register access is not used
            ctl.cre   <= 1'b0;
            ctl.addr  <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    lat_cnt <= '0;
                    if (req.valid) begin
                        state     <= S_ADDR;
                        write_q   <= req.write;
                        ctl.ce_n  <= 1'b0;
                        ctl.adv_n <= 1'b0;
                        ctl.addr  <= req.addr;
                        // Reads always return both bytes
                        ctl.ub_n  <= req.write ? !req.strb[1] : 1'b0;
                        ctl.lb_n  <= req.write ? !req.strb[0] : 1'b0;
                    end
                end
                S_ADDR: begin
                    state     <= S_WAIT;
                    ctl.adv_n <= 1'b1;
                    ctl.we_n  <= !write_q;
                    drv_q     <= write_q;
                end
                S_WAIT: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == CNT_W'(`PSRAM_LATENCY - 1)) begin
                        if (write_q) begin
                            // Rising we_n is where the chip takes the data
                            state    <= S_WDATA;
                            ctl.we_n <= 1'b1;
                        end else begin
                            state    <= S_RDATA;
                            ctl.oe_n <= 1'b0;
                        end
                    end
                end
                S_RDATA: begin
                    state    <= S_IDLE;
                    done_q   <= 1'b1;
                    ctl.ce_n <= 1'b1;
                    ctl.oe_n <= 1'b1;
                    ctl.ub_n <= 1'b1;
                    ctl.lb_n <= 1'b1;
                end
                S_WDATA: begin
                    // Data held one cycle past we_n for hold time
                    state    <= S_IDLE;
                    done_q   <= 1'b1;
                    drv_q    <= 1'b0;
                    ctl.ce_n <= 1'b1;
                    ctl.ub_n <= 1'b1;
                    ctl.lb_n <= 1'b1;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (state == S_IDLE && req.valid) begin
            wdata_q <= req.wdata;
        end
        // Sampled at the end of the data cycle
        if (state == S_RDATA) begin
            rdata_q <= mdata;
        end
    end

    // Bus contention on the chip if both were low
    assert property (@(posedge clk50MHz) disable iff (!rst_n) !(!ctl.oe_n && !ctl.we_n))
        else $error("oe_n and we_n low together");

    // The decoder waits for the APB response, so a bank is never hit while busy
    assert property (@(posedge clk50MHz) disable iff (!rst_n) req.valid |-> state == S_IDLE)
        else $error("request to a busy bank");

endmodule

// File: rtl/apb_bank_decoder.sv
`include "psram_cfg.svh"

module apb_bank_decoder (
    input  logic                                         clk50MHz,
    input  logic                                         rst_n,
    input  logic [`PSRAM_PADDR_W-1:0]                    paddr,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [`PSRAM_DATA_W-1:0]                     pwdata,
    input  logic [`PSRAM_DATA_W/8-1:0]                   pstrb,
    input  logic                                         busy,
    output psram_pkg::bank_req_t [`PSRAM_NUM_BANKS-1:0]  req,
    output logic                                         err
);
    // Byte address: bit 0 selects the byte within a word
    localparam int WORD_LSB = 1;
    localparam int BANK_LSB = `PSRAM_ADDR_W + 1;

    logic                           access;
    logic                           start;
    logic                           pend_q;
    logic                           go_q;
    logic                           in_range;
    logic [`PSRAM_BANK_W-1:0]       bank_sel;
    logic [`PSRAM_NUM_BANKS-1:0]    valid_q;
    logic                           write_q;
    logic [`PSRAM_ADDR_W-1:0]       addr_q;
    logic [`PSRAM_DATA_W-1:0]       wdata_q;
    logic [`PSRAM_DATA_W/8-1:0]     strb_q;

    assign access   = psel && penable;
    // One start per transfer, rearmed once the response stage has answered
    assign start    = access && !pend_q && !busy;
    assign bank_sel = paddr[BANK_LSB +: `PSRAM_BANK_W];
    // Every bit above the word address counts toward the bank number
    assign in_range = paddr[`PSRAM_PADDR_W-1:BANK_LSB] < `PSRAM_NUM_BANKS;

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            pend_q  <= 1'b0;
            go_q    <= 1'b0;
            valid_q <= '0;
            err     <= 1'b0;
        end else begin
            go_q <= start;
            if (start) begin
                pend_q <= 1'b1;
            end else if (busy) begin
                pend_q <= 1'b0;
            end
            valid_q <= '0;
            if (go_q && in_range) begin
                valid_q[bank_sel] <= 1'b1;
            end
            err <= go_q && !in_range;
        end
    end

    // Request payload, shared by all banks
    always_ff @(posedge clk50MHz) begin
        if (go_q) begin
            write_q <= pwrite;
            addr_q  <= paddr[WORD_LSB +: `PSRAM_ADDR_W];
            wdata_q <= pwdata;
            strb_q  <= pstrb;
        end
    end

    always_comb begin
        for (int b = 0; b < `PSRAM_NUM_BANKS; b++) begin
            req[b].valid = valid_q[b];
            req[b].write = write_q;
            req[b].addr  = addr_q;
            req[b].wdata = wdata_q;
            req[b].strb  = strb_q;
        end
    end

    // A hand-off only for an access still held and an idle response stage
    assert property (@(posedge clk50MHz) disable iff (!rst_n)
                     (|valid_q || err) |-> access && !busy)
        else $error("hand-off outside a held access or while busy");

endmodule

// File: rtl/psram_pkg.sv
`include "psram_cfg.svh"

package psram_pkg;

    // One request from the APB decoder to one bank
    typedef struct packed {
        logic                           valid;
        logic                           write;
        logic [`PSRAM_ADDR_W-1:0]       addr;
        logic [`PSRAM_DATA_W-1:0]       wdata;
        // Bit 1 upper byte, bit 0 lower byte
        logic [`PSRAM_DATA_W/8-1:0]     strb;
    } bank_req_t;

    // Control pins of one chip, all active low except cre
    typedef struct packed {
        logic                           ce_n;
        logic                           adv_n;
        logic                           oe_n;
        logic                           we_n;
        logic                           ub_n;
        logic                           lb_n;
        logic                           cre;
        logic [`PSRAM_ADDR_W-1:0]       addr;
    } psram_ctl_t;

    // Completion of one access
    typedef struct packed {
        logic                           done;
        logic [`PSRAM_DATA_W-1:0]       rdata;
    } bank_rsp_t;

endpackage

// File: rtl/psram_cfg.svh
`ifndef PSRAM_CFG_SVH
`define PSRAM_CFG_SVH

// Number of pseudo-SRAM chips, one bank controller each
`define PSRAM_NUM_BANKS 4

// Word address width of a single chip
`define PSRAM_ADDR_W 12

// Chip data bus, two byte lanes
`define PSRAM_DATA_W 16

// Cycles spent in the wait state of every access
`define PSRAM_LATENCY 4

// Bank select bits taken from the APB address above the word address
`define PSRAM_BANK_W 2

// APB address bus
`define PSRAM_PADDR_W 32

`endif
